// File: sel_loop_pkg.sv
package sel_loop_pkg;

	// signed sample, setpoint and coefficient word
	typedef logic signed [17:0] word_t;
	// phase output carries one extra lsb
	typedef logic signed [18:0] phase_t;

	// cycles between cordic sync pulses
	localparam int FRAME_LEN = 8;
	// cordic gain compensation of the magnitude setpoint, 17-bit fraction
	localparam word_t SET_SCALE = 18'sd96667;
	// one radian as a 17-bit fraction of a revolution
	localparam int RAD_UNIT = 20861;

	// host table select codes
	localparam logic [1:0] TBL_SETMP = 2'd0;
	localparam logic [1:0] TBL_COEFF = 2'd1;
	localparam logic [1:0] TBL_LIM = 2'd2;

	typedef struct packed {
		logic sel_en;
		logic ff_en;
		word_t ph_offset;
		word_t sel_thresh;
		word_t ff_setm;
		word_t ff_setp;
		word_t ff_ddrive;
	} loop_ctrl_t;

	typedef struct packed {
		logic [1:0] tbl;
		logic [1:0] addr;
		word_t data;
	} host_wr_t;

	// x_hi lands in bit 0, y_lo in bit 3
	typedef struct packed {
		logic y_lo;
		logic x_lo;
		logic y_hi;
		logic x_hi;
	} clip_t;

	// over: even bits magnitude, odd bits phase, ladder /1 /2 /4 /8
	typedef struct packed {
		clip_t clip;
		logic [7:0] over;
	} cmp_event_t;

endpackage

// File: reg_delay.sv
`timescale 1ns/100ps

module reg_delay #(
	// payload carried down the line
	parameter type dtype = logic,
	// latency in cycles, at least one
	parameter int len = 1
) (
	input logic clk,
	input logic rst_n,
	input dtype din,
	output dtype dout
);

	dtype sr [len];

	// plain shift register, stage 0 takes din
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < len; i++) begin
				sr[i] <= '0;
			end
		end else begin
			sr[0] <= din;
			for (int i = 1; i < len; i++) begin
				sr[i] <= sr[i-1];
			end
		end
	end

	assign dout = sr[len-1];

endmodule

// File: pdetect.sv
`timescale 1ns/100ps

module pdetect
	import sel_loop_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input word_t ang_in,
	input logic strobe_in,
	input logic clear,
	output word_t ang_out
);

	// last strobed input and extended angle
	word_t prev_ang;
	word_t hist;
	word_t delta;
	logic signed [18:0] hist_sum;
	word_t hist_sat;

	always_comb begin
		// difference wraps in 18 bits, so a jump across +-pi is a small step
		delta = ang_in - prev_ang;
		hist_sum = hist + delta;
		hist_sat = hist_sum[17:0];
		// clamp at full scale rather than wrap
		if (hist_sum[18] != hist_sum[17]) begin
			hist_sat = {hist_sum[18], {17{~hist_sum[18]}}};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_ang <= '0;
			hist <= '0;
			ang_out <= '0;
		end else if (strobe_in) begin
			prev_ang <= ang_in;
			// cleared history just tracks the raw angle
			hist <= clear ? ang_in : hist_sat;
			ang_out <= clear ? ang_in : hist_sat;
		end else begin
			// off-strobe words pass through one register
			ang_out <= ang_in;
		end
	end

endmodule

// File: xy_pi_clip.sv
`timescale 1ns/100ps

module xy_pi_clip
	import sel_loop_pkg::*;
#(
	parameter int ff_dshift = 0
) (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input word_t in_err,
	input word_t coeff,
	input word_t lim,
	input logic ff_en,
	input word_t ff_ddrive,
	output word_t out_xy,
	output clip_t clipped
);

	// t0 is the sync cycle, in_err holds err_x at t0 and err_y at t1
	// coeff stream t0..t3 is ki_x ki_y kp_x kp_y
	// lim stream t1..t4 is hi_x hi_y lo_x lo_y
	logic [3:0] stage;
	word_t e1, e2, mul_err;
	logic signed [35:0] prod;
	logic signed [18:0] term;
	word_t integ [2];
	word_t hi_q [2];
	word_t ff_term;
	logic ax;
	logic signed [19:0] acc, sum;
	word_t acc_sat;
	logic hi_f, lo_f;
	word_t out_q;
	clip_t clip_q;

	always_comb begin
		// ki products use the live error, kp products the twice delayed one
		mul_err = (stage[1] | stage[2]) ? e2 : in_err;
		term = prod[35:17];
		ff_term = ff_en ? (ff_ddrive >>> ff_dshift) : 18'sd0;
		// y axis works at t2 (integrate) and t4 (output)
		ax = stage[1] | stage[3];
		acc = integ[ax] + term + ff_term;
		acc_sat = acc[17:0];
		if (acc > 20'sd131071) begin
			acc_sat = 18'sh1ffff;
		end else if (acc < -20'sd131072) begin
			acc_sat = 18'sh20000;
		end
		// output includes this frame's integrator step
		sum = integ[ax] + term;
		hi_f = sum > hi_q[ax];
		lo_f = sum < lim;
	end

	always_ff @(posedge clk) begin
		e1 <= in_err;
		e2 <= e1;
		prod <= mul_err * coeff;
		if (stage[0])
			hi_q[0] <= lim;
		if (stage[1])
			hi_q[1] <= lim;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= '0;
			integ[0] <= '0;
			integ[1] <= '0;
			out_q <= '0;
			clip_q <= '0;
		end else begin
			stage <= {stage[2:0], sync};
			if (stage[0] | stage[1]) begin
				integ[ax] <= acc_sat;
			end else if (stage[2] | stage[3]) begin
				if (hi_f) begin
					out_q <= hi_q[ax];
					// anti-windup, integrator stays inside the limits
					if (integ[ax] > hi_q[ax])
						integ[ax] <= hi_q[ax];
				end else if (lo_f) begin
					out_q <= lim;
					if (integ[ax] < lim)
						integ[ax] <= lim;
				end else begin
					out_q <= sum[17:0];
				end
				if (ax) begin
					clip_q.y_hi <= hi_f;
					clip_q.y_lo <= lo_f;
				end else begin
					clip_q.x_hi <= hi_f;
					clip_q.x_lo <= lo_f;
				end
			end
		end
	end

	assign out_xy = out_q;
	assign clipped = clip_q;

	// host must keep lo at or below hi in the limit table
	a_clip_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(clip_q.x_hi && clip_q.x_lo) && !(clip_q.y_hi && clip_q.y_lo));

endmodule

// File: mp_proc.sv
`timescale 1ns/100ps

module mp_proc
	import sel_loop_pkg::*;
#(
	parameter int thresh_shift = 9,
	parameter int ff_dshift = 0
) (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input word_t in_mp,
	input loop_ctrl_t ctrl,
	input word_t setmp,
	input word_t coeff,
	input word_t lim,
	output logic [1:0] setmp_addr,
	output logic [1:0] coeff_addr,
	output logic [1:0] lim_addr,
	output logic out_sync,
	output word_t out_xy,
	output phase_t out_ph,
	output cmp_event_t cmp_event
);

	logic [2:0] slot_q, cur_slot;
	logic sync_d1, sync_d2;
	logic sel_amp_ok;
	word_t setmp_mux, mp_err, pd_err;
	word_t setm_q, setp_q, set_hold;
	logic signed [35:0] set_full;
	phase_t ph_stream;
	word_t pi_xy, xy_d1, xy_d2, out_q;
	clip_t pi_clip, clip_d;
	logic [16:0] pd_abs, abs_m, abs_p, thr_m, thr_p;
	logic [7:0] over_w;
	cmp_event_t cmp_q;

	always_comb begin
		cur_slot = sync ? 3'd0 : slot_q + 3'd1;
		// table reads land one cycle after the address
		// setmp gives magnitude at slot 0 and phase at slot 1
		setmp_addr = {1'b0, cur_slot == 3'd0};
		// pi wants ki_x ki_y kp_x kp_y on slots 1..4
		case (cur_slot)
			3'd0: coeff_addr = 2'd1;
			3'd1: coeff_addr = 2'd3;
			3'd2: coeff_addr = 2'd0;
			default: coeff_addr = 2'd2;
		endcase
		// limits hi_x hi_y lo_x lo_y on slots 2..5
		lim_addr = 2'(cur_slot - 3'd1);
		if (ctrl.ff_en)
			setmp_mux = (cur_slot == 3'd0) ? ctrl.ff_setm : ctrl.ff_setp;
		else
			setmp_mux = setmp;
		mp_err = in_mp - setmp_mux;
		// phase words for next frame, drv_p at slot 1 and set_p at slot 3
		ph_stream = '0;
		if (cur_slot == 3'd1 && ctrl.sel_en && sel_amp_ok) begin
			ph_stream = {in_mp + ctrl.ph_offset, 1'b0};
		end else if (cur_slot == 3'd3) begin
			ph_stream = {setp_q, 1'b0};
		end
		set_full = setm_q * SET_SCALE;
		// ones-complement abs, -1 reads as 0
		pd_abs = pd_err[17] ? ~pd_err[16:0] : pd_err[16:0];
		thr_m = 17'(setm_q >>> thresh_shift);
		thr_p = 17'(RAD_UNIT >> thresh_shift);
		for (int k = 0; k < 4; k++) begin
			over_w[2*k] = abs_m > (thr_m >> k);
			over_w[2*k+1] = abs_p > (thr_p >> k);
		end
	end

	// magnitude error out at slot 1, extended phase error at slot 2
	pdetect i_pdetect (.clk(clk), .rst_n(rst_n), .ang_in(mp_err), .strobe_in(sync_d1),
		.clear(~sel_amp_ok), .ang_out(pd_err));

	// drive x at slot 5, y at slot 6
	xy_pi_clip #(.ff_dshift(ff_dshift)) i_pi (.clk(clk), .rst_n(rst_n), .sync(sync_d1),
		.in_err(pd_err), .coeff(coeff), .lim(lim), .ff_en(ctrl.ff_en),
		.ff_ddrive(ctrl.ff_ddrive), .out_xy(pi_xy), .clipped(pi_clip));

	// one frame from slot 1 to slot 1 of the next frame
	reg_delay #(.dtype(phase_t), .len(FRAME_LEN)) i_ph_dly (.clk(clk), .rst_n(rst_n),
		.din(ph_stream), .dout(out_ph));

	// clip flags settle at slot 6, picked up with the over bits at slot 7
	reg_delay #(.dtype(clip_t), .len(1)) i_clip_dly (.clk(clk), .rst_n(rst_n),
		.din(pi_clip), .dout(clip_d));

	always_ff @(posedge clk) begin
		xy_d1 <= pi_xy;
		xy_d2 <= xy_d1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_q <= '0;
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			sel_amp_ok <= 1'b0;
			setm_q <= '0;
			setp_q <= '0;
			set_hold <= '0;
			abs_m <= '0;
			abs_p <= '0;
			out_q <= '0;
			cmp_q <= '0;
		end else begin
			slot_q <= cur_slot;
			sync_d1 <= sync;
			sync_d2 <= sync_d1;
			// hysteresis on amplitude, the phase is noise at low level
			if (sync) begin
				setm_q <= setmp_mux;
				if (in_mp > ctrl.sel_thresh)
					sel_amp_ok <= 1'b1;
				else if (in_mp < (ctrl.sel_thresh >>> 1))
					sel_amp_ok <= 1'b0;
			end
			if (sync_d1) begin
				setp_q <= setmp_mux;
				abs_m <= pd_abs;
			end
			if (sync_d2)
				abs_p <= pd_abs;
			// frame results handed over just before the next sync
			if (cur_slot == 3'd7) begin
				set_hold <= set_full[34:17];
				cmp_q <= '{clip: clip_d, over: over_w};
			end
			case (cur_slot)
				3'd7, 3'd0: out_q <= xy_d2;
				3'd1: out_q <= set_hold;
				default: out_q <= '0;
			endcase
		end
	end

	assign out_sync = sync;
	assign out_xy = out_q;
	assign cmp_event = cmp_q;

	// cordic framing is fixed, every sync is followed by the next one 8 cycles on
	a_sync_period: assert property (@(posedge clk) disable iff (!rst_n)
		sync |=> !sync [*FRAME_LEN-1] ##1 sync);

endmodule

// File: ctrl_regs.sv
`timescale 1ns/100ps

module ctrl_regs
	import sel_loop_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic host_we,
	input host_wr_t host_wr,
	input logic [1:0] setmp_addr,
	input logic [1:0] coeff_addr,
	input logic [1:0] lim_addr,
	output word_t setmp,
	output word_t coeff,
	output word_t lim
);

	// setmp 0 magnitude 1 phase
	word_t setmp_tab [4];
	// kp_x ki_x kp_y ki_y
	word_t coeff_tab [4];
	// hi_x hi_y lo_x lo_y
	word_t lim_tab [4];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				setmp_tab[i] <= '0;
				coeff_tab[i] <= '0;
				lim_tab[i] <= '0;
			end
		end else if (host_we) begin
			// one entry per write strobe, code 3 is ignored
			case (host_wr.tbl)
				TBL_SETMP: setmp_tab[host_wr.addr] <= host_wr.data;
				TBL_COEFF: coeff_tab[host_wr.addr] <= host_wr.data;
				TBL_LIM: lim_tab[host_wr.addr] <= host_wr.data;
				default: ;
			endcase
		end
	end

	// registered reads, one cycle latency
	always_ff @(posedge clk) begin
		setmp <= setmp_tab[setmp_addr];
		coeff <= coeff_tab[coeff_addr];
		lim <= lim_tab[lim_addr];
	end

endmodule

// File: sel_loop_top.sv
`timescale 1ns/100ps

module sel_loop_top
	import sel_loop_pkg::*;
#(
	// lock ladder starts at setpoint >> thresh_shift
	parameter int thresh_shift = 9,
	// downshift of the feed-forward drive step
	parameter int ff_dshift = 0
) (
	input logic clk,
	input logic rst_n,
	input logic sync,
	input word_t in_mp,
	input loop_ctrl_t ctrl,
	input logic host_we,
	input host_wr_t host_wr,
	output logic out_sync,
	output word_t out_xy,
	output phase_t out_ph,
	output cmp_event_t cmp_event
);

	// per-slot table lookups between processor and register file
	logic [1:0] setmp_addr, coeff_addr, lim_addr;
	word_t setmp, coeff, lim;

	ctrl_regs i_ctrl_regs (.clk(clk), .rst_n(rst_n), .host_we(host_we), .host_wr(host_wr),
		.setmp_addr(setmp_addr), .coeff_addr(coeff_addr), .lim_addr(lim_addr),
		.setmp(setmp), .coeff(coeff), .lim(lim));

	mp_proc #(.thresh_shift(thresh_shift), .ff_dshift(ff_dshift)) i_mp_proc (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp), .ctrl(ctrl),
		.setmp(setmp), .coeff(coeff), .lim(lim),
		.setmp_addr(setmp_addr), .coeff_addr(coeff_addr), .lim_addr(lim_addr),
		.out_sync(out_sync), .out_xy(out_xy), .out_ph(out_ph), .cmp_event(cmp_event));

endmodule

// File: tb_sel_loop.sv
`timescale 1ns/100ps

module tb_sel_loop
	import sel_loop_pkg::*;
();

	localparam int thresh_shift = 9;
	localparam int ff_dshift = 0;

	// expected slots of one output frame
	typedef struct packed {
		logic [7:0][17:0] xy;
		logic [7:0][18:0] ph;
		cmp_event_t ev;
	} frame_exp_t;

	logic clk, rst_n, sync, host_we, out_sync;
	word_t in_mp, out_xy;
	loop_ctrl_t ctrl, ctrl_next;
	host_wr_t host_wr;
	phase_t out_ph;
	cmp_event_t cmp_event;

	// mirror of the host tables and of the loop state
	word_t setmp_m [4];
	word_t coeff_m [4];
	word_t lim_m [4];
	word_t integ_m [2];
	word_t hist_m, prev_m;
	logic sel_ok_m;
	host_wr_t wr_q [$];
	frame_exp_t exp_q [$];
	int checks, errors, checks0, errors0;

	sel_loop_top #(.thresh_shift(thresh_shift), .ff_dshift(ff_dshift)) i_sel_loop_top (
		.clk(clk), .rst_n(rst_n), .sync(sync), .in_mp(in_mp), .ctrl(ctrl),
		.host_we(host_we), .host_wr(host_wr), .out_sync(out_sync), .out_xy(out_xy),
		.out_ph(out_ph), .cmp_event(cmp_event));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check(input string name, input logic signed [31:0] got,
			input logic signed [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// one axis of the controller, integrator first, then output with clipping
	function automatic void pi_step(input int ax, input word_t err, input word_t kp,
			input word_t ki, input word_t hi, input word_t lo, input longint ffv,
			output word_t drv, output logic hi_f, output logic lo_f);
		longint acc, sum;
		acc = longint'(integ_m[ax]) + ((longint'(ki) * longint'(err)) >>> 17) + ffv;
		if (acc > 131071)
			acc = 131071;
		else if (acc < -131072)
			acc = -131072;
		integ_m[ax] = word_t'(acc);
		sum = longint'(integ_m[ax]) + ((longint'(kp) * longint'(err)) >>> 17);
		hi_f = sum > longint'(hi);
		lo_f = sum < longint'(lo);
		if (hi_f) begin
			drv = hi;
			if (integ_m[ax] > hi)
				integ_m[ax] = hi;
		end else if (lo_f) begin
			drv = lo;
			if (integ_m[ax] < lo)
				integ_m[ax] = lo;
		end else begin
			drv = word_t'(sum);
		end
	endfunction

	// reference for one input frame, its slots show up in the next frame
	function automatic frame_exp_t model_frame(input word_t mag, input word_t ph);
		frame_exp_t r;
		word_t setm, setp, err_m, err_p, delta, drv_x, drv_y;
		logic xh, xl, yh, yl;
		longint s, ffv, abs_m, abs_p, thr_m, thr_p;
		r = '0;
		setm = ctrl.ff_en ? ctrl.ff_setm : setmp_m[0];
		setp = ctrl.ff_en ? ctrl.ff_setp : setmp_m[1];
		// amplitude hysteresis on the raw magnitude
		if (mag > ctrl.sel_thresh)
			sel_ok_m = 1'b1;
		else if (mag < (ctrl.sel_thresh >>> 1))
			sel_ok_m = 1'b0;
		err_m = mag - setm;
		err_p = ph - setp;
		// phase extension, wrapped step and saturated sum
		if (!sel_ok_m) begin
			hist_m = err_p;
		end else begin
			delta = err_p - prev_m;
			s = longint'(hist_m) + longint'(delta);
			if (s > 131071)
				s = 131071;
			else if (s < -131072)
				s = -131072;
			hist_m = word_t'(s);
		end
		prev_m = err_p;
		ffv = ctrl.ff_en ? (longint'(ctrl.ff_ddrive) >>> ff_dshift) : 0;
		pi_step(0, err_m, coeff_m[0], coeff_m[1], lim_m[0], lim_m[2], ffv, drv_x, xh, xl);
		pi_step(1, hist_m, coeff_m[2], coeff_m[3], lim_m[1], lim_m[3], ffv, drv_y, yh, yl);
		r.xy[0] = drv_x;
		r.xy[1] = drv_y;
		r.xy[2] = word_t'((longint'(setm) * longint'(SET_SCALE)) >>> 17);
		if (ctrl.sel_en && sel_ok_m)
			r.ph[1] = {word_t'(ph + ctrl.ph_offset), 1'b0};
		r.ph[3] = {setp, 1'b0};
		// ones-complement magnitude of the errors
		abs_m = (err_m < 0) ? -longint'(err_m) - 1 : longint'(err_m);
		abs_p = (hist_m < 0) ? -longint'(hist_m) - 1 : longint'(hist_m);
		thr_m = (longint'(setm) >>> thresh_shift) & 'h1ffff;
		thr_p = RAD_UNIT >> thresh_shift;
		for (int k = 0; k < 4; k++) begin
			r.ev.over[2*k] = abs_m > (thr_m >> k);
			r.ev.over[2*k+1] = abs_p > (thr_p >> k);
		end
		r.ev.clip = '{y_lo: yl, x_lo: xl, y_hi: yh, x_hi: xh};
		return r;
	endfunction

	task automatic queue_write(input logic [1:0] tbl, input logic [1:0] addr, input word_t data);
		host_wr_t w;
		w.tbl = tbl;
		w.addr = addr;
		w.data = data;
		wr_q.push_back(w);
	endtask

	task automatic drive_write();
		host_wr_t w;
		if (wr_q.size() > 0) begin
			w = wr_q.pop_front();
			host_we <= 1'b1;
			host_wr <= w;
			case (w.tbl)
				TBL_SETMP: setmp_m[w.addr] = w.data;
				TBL_COEFF: coeff_m[w.addr] = w.data;
				TBL_LIM: lim_m[w.addr] = w.data;
				default: ;
			endcase
		end else begin
			host_we <= 1'b0;
		end
	endtask

	// one eight-cycle frame, magnitude at slot 0 and phase at slot 1
	task automatic run_frame(input word_t mag, input word_t ph);
		frame_exp_t e;
		e = model_frame(mag, ph);
		@(posedge clk);
		sync <= 1'b1;
		in_mp <= mag;
		@(posedge clk);
		sync <= 1'b0;
		in_mp <= ph;
		@(posedge clk);
		in_mp <= '0;
		repeat (2) @(posedge clk);
		// slots 5 and 6 have no table read in flight
		@(posedge clk);
		ctrl <= ctrl_next;
		drive_write();
		@(posedge clk);
		drive_write();
		@(posedge clk);
		host_we <= 1'b0;
		exp_q.push_back(e);
	endtask

	task automatic settle();
		do begin
			run_frame(word_t'($urandom), word_t'($urandom));
		end while (wr_q.size() > 0);
	endtask

	task automatic end_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name, checks - checks0,
			errors - errors0);
		checks0 = checks;
		errors0 = errors;
	endtask

	// compares every slot of each output frame against the queued reference
	initial begin
		frame_exp_t e;
		int wait_n;
		forever begin
			wait_n = 0;
			do begin
				@(negedge clk);
				wait_n++;
			end while (!out_sync && wait_n < 3 * FRAME_LEN);
			if (!out_sync) begin
				$display("timeout: out_sync did not arrive within %0d cycles", 3 * FRAME_LEN);
				$display("TESTBENCH FAILED");
				$finish;
			end
			if (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				for (int k = 0; k < FRAME_LEN; k++) begin
					if (k > 0)
						@(negedge clk);
					// out_sync follows sync, high in slot 0 only
					check($sformatf("out_sync[%0d]", k), out_sync, k == 0);
					check($sformatf("out_xy[%0d]", k), $signed(out_xy), $signed(e.xy[k]));
					check($sformatf("out_ph[%0d]", k), $signed(out_ph), $signed(e.ph[k]));
					check($sformatf("cmp_event[%0d]", k), {20'd0, cmp_event}, {20'd0, e.ev});
				end
			end
		end
	end

	initial begin
		int mag_err [10] = '{79, 78, 40, 39, 20, 19, 10, 9, 0, -80};
		int ph_err [10] = '{41, 40, 21, 20, 11, 10, 6, 5, 0, -42};
		int sel_mag [6] = '{25000, 15000, 5000, 15000, 30000, 10000};
		void'($urandom(11159));
		rst_n = 1'b0;
		sync = 1'b0;
		in_mp = '0;
		ctrl = '0;
		ctrl_next = '0;
		host_we = 1'b0;
		host_wr = '0;
		checks = 0;
		errors = 0;
		checks0 = 0;
		errors0 = 0;
		for (int i = 0; i < 4; i++) begin
			setmp_m[i] = '0;
			coeff_m[i] = '0;
			lim_m[i] = '0;
		end
		integ_m[0] = '0;
		integ_m[1] = '0;
		hist_m = '0;
		prev_m = '0;
		sel_ok_m = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// table setpoints, then feed-forward setpoints
		queue_write(TBL_SETMP, 2'd0, word_t'($urandom));
		queue_write(TBL_SETMP, 2'd1, word_t'($urandom));
		settle();
		repeat (4) run_frame(word_t'($urandom), word_t'($urandom));
		ctrl_next.ff_en = 1'b1;
		ctrl_next.ff_setm = word_t'($urandom);
		ctrl_next.ff_setp = word_t'($urandom);
		ctrl_next.ff_ddrive = 18'sd5;
		settle();
		repeat (4) run_frame(word_t'($urandom), word_t'($urandom));
		end_test("setpoint_slots");

		// hysteresis band is 10000 to 20000
		ctrl_next = '0;
		ctrl_next.sel_en = 1'b1;
		ctrl_next.sel_thresh = 18'sd20000;
		ctrl_next.ph_offset = word_t'($urandom);
		settle();
		for (int i = 0; i < 6; i++)
			run_frame(word_t'(sel_mag[i]), word_t'($urandom));
		ctrl_next.sel_en = 1'b0;
		settle();
		repeat (2) run_frame(18'sd30000, word_t'($urandom));
		end_test("sel_hysteresis");

		// kp only, limits at full scale
		queue_write(TBL_COEFF, 2'd0, word_t'($urandom_range(1, 131071)));
		queue_write(TBL_COEFF, 2'd1, '0);
		queue_write(TBL_COEFF, 2'd2, word_t'($urandom_range(1, 131071)));
		queue_write(TBL_COEFF, 2'd3, '0);
		queue_write(TBL_LIM, 2'd0, 18'sd131071);
		queue_write(TBL_LIM, 2'd1, 18'sd131071);
		queue_write(TBL_LIM, 2'd2, -18'sd131072);
		queue_write(TBL_LIM, 2'd3, -18'sd131072);
		settle();
		repeat (8) run_frame(word_t'($urandom), word_t'($urandom));
		end_test("proportional");

		queue_write(TBL_COEFF, 2'd1, word_t'($urandom_range(1, 4000)));
		queue_write(TBL_COEFF, 2'd3, word_t'($urandom_range(1, 4000)));
		settle();
		repeat (10) run_frame(word_t'($urandom), word_t'($urandom));
		end_test("integration");

		// narrow window so most drives hit a bound
		queue_write(TBL_LIM, 2'd0, 18'sd1000);
		queue_write(TBL_LIM, 2'd1, 18'sd800);
		queue_write(TBL_LIM, 2'd2, -18'sd1000);
		queue_write(TBL_LIM, 2'd3, -18'sd800);
		settle();
		repeat (10) run_frame(word_t'($urandom), word_t'($urandom));
		end_test("clipping");

		// setpoint 40000 puts the magnitude ladder at 78 39 19 9, phase at 40 20 10 5
		ctrl_next.sel_thresh = 18'sd131071;
		for (int i = 0; i < 4; i++)
			queue_write(TBL_COEFF, 2'(i), '0);
		queue_write(TBL_SETMP, 2'd0, 18'sd40000);
		queue_write(TBL_SETMP, 2'd1, 18'sd1000);
		settle();
		for (int i = 0; i < 10; i++)
			run_frame(word_t'(40000 + mag_err[i]), word_t'(1000 + ph_err[i]));
		end_test("lock_events");

		// flush frame lets the last test frame reach the outputs
		run_frame('0, '0);
		@(negedge clk);
		@(posedge clk);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
sel_loop_pkg.sv
reg_delay.sv
pdetect.sv
xy_pi_clip.sv
mp_proc.sv
ctrl_regs.sv
sel_loop_top.sv
tb_sel_loop.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_sel_loop \
	-Mdir obj_dir -o sim_tb_sel_loop
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_sel_loop)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
